//--- hdl/sc64_pkg.sv
`default_nettype none

package sc64_pkg;

    localparam int PI_W   = 16;
    localparam int REG_AW = 3;
    localparam int REG_DW = 32;

    localparam logic [REG_AW-1:0] REG_GPIO      = 3'd0;
    localparam logic [REG_AW-1:0] REG_CFG       = 3'd1;
    localparam logic [REG_AW-1:0] REG_MEM_ADDR  = 3'd2;
    localparam logic [REG_AW-1:0] REG_MEM_DATA  = 3'd3;
    localparam logic [REG_AW-1:0] REG_PI_STATUS = 3'd4;

    localparam logic [3:0] CART_REGION = 4'd1;  // Cartridge area at 0x1xxx_xxxx.

    // The bus delivers the address as two words.
    typedef struct packed {
        logic [PI_W-1:0] high;
        logic [PI_W-1:0] low;
    } pi_halves_t;

    // The decoder sees a region nibble and a byte offset.
    typedef struct packed {
        logic [3:0]  region;
        logic [27:0] offset;
    } pi_fields_t;

    typedef union packed {
        pi_halves_t halves;
        pi_fields_t fields;
    } pi_addr_t;

endpackage

`default_nettype wire

//--- hdl/n64_sync.sv
`timescale 1ns/100ps
`default_nettype none

module n64_sync (
    input  logic       i_sys_clk,
    input  logic       i_arst_n,
    input  logic       i_n64_reset,
    input  logic       i_n64_nmi,
    input  logic [1:0] i_pin_state,
    output logic       o_n64_reset,
    output logic       o_n64_nmi,
    output logic [7:0] o_gpio_in
);

    logic [1:0] reset_ff;
    logic [1:0] nmi_ff;
    logic [7:0] gpio_in;

    always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            reset_ff <= 2'b00;
            nmi_ff   <= 2'b00;
        end else begin
            reset_ff <= {reset_ff[0], i_n64_reset};
            nmi_ff   <= {nmi_ff[0], i_n64_nmi};
        end
    end

    // Bits 1:0 carry the driven irq and LED values.
    always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            gpio_in <= 8'h00;
        end else begin
            gpio_in <= {4'b0000, nmi_ff[1], reset_ff[1], i_pin_state};
        end
    end

    assign o_n64_reset = reset_ff[1];
    assign o_n64_nmi   = nmi_ff[1];
    assign o_gpio_in   = gpio_in;

endmodule

`default_nettype wire

//--- hdl/n64_pi.sv
`timescale 1ns/100ps
`default_nettype none

module n64_pi #(
    parameter int MEM_AW = 10
) (
    input  logic                      i_sys_clk,
    input  logic                      i_arst_n,
    input  logic                      i_pi_aleh,
    input  logic                      i_pi_alel,
    input  logic                      i_pi_read_n,
    input  logic                      i_pi_write_n,
    input  logic [sc64_pkg::PI_W-1:0] i_pi_ad,
    input  logic                      i_wr_en,
    input  logic [sc64_pkg::PI_W-1:0] i_mem_rdata,
    output logic [sc64_pkg::PI_W-1:0] o_pi_ad,
    output logic                      o_pi_ad_oe,
    output logic [MEM_AW-1:0]         o_mem_addr,
    output logic                      o_mem_we,
    output logic [sc64_pkg::PI_W-1:0] o_mem_wdata,
    output sc64_pkg::pi_addr_t        o_pi_addr
);

    // Strobe vector order is aleh, alel, read_n, write_n.
    localparam logic [3:0] STRB_IDLE = 4'b0011;  // Bus idle has both ALE low.

    logic [3:0]                strb_meta;
    logic [3:0]                strb_sync;
    logic [3:0]                strb_prev;
    logic [sc64_pkg::PI_W-1:0] ad_meta;
    logic [sc64_pkg::PI_W-1:0] ad_sync;
    sc64_pkg::pi_addr_t        addr;
    logic                      aleh_fall;
    logic                      alel_fall;
    logic                      read_fall;
    logic                      read_rise;
    logic                      write_rise;
    logic                      cart_hit;
    logic [sc64_pkg::PI_W-1:0] rd_data;
    logic                      rd_oe;

    always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            strb_meta <= STRB_IDLE;
            strb_sync <= STRB_IDLE;
            strb_prev <= STRB_IDLE;
        end else begin
            strb_meta <= {i_pi_aleh, i_pi_alel, i_pi_read_n, i_pi_write_n};
            strb_sync <= strb_meta;
            strb_prev <= strb_sync;
        end
    end

    always_ff @(posedge i_sys_clk) begin
        ad_meta <= i_pi_ad;
        ad_sync <= ad_meta;
    end

    assign aleh_fall  = strb_prev[3] & ~strb_sync[3];
    assign alel_fall  = strb_prev[2] & ~strb_sync[2];
    assign read_fall  = strb_prev[1] & ~strb_sync[1];
    assign read_rise  = ~strb_prev[1] & strb_sync[1];
    assign write_rise = ~strb_prev[0] & strb_sync[0];

    assign cart_hit = (addr.fields.region == sc64_pkg::CART_REGION);

    always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            addr <= '0;
        end else begin
            if (aleh_fall) begin
                addr.halves.high <= ad_sync;
            end
            if (alel_fall) begin
                addr.halves.low <= ad_sync;
            end
            if (read_rise || write_rise) begin
                addr.fields.offset <= addr.fields.offset + 28'd2;  // Next 16-bit word.
            end
        end
    end

    // Memory output already holds the word at the current offset.
    always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rd_oe   <= 1'b0;
            rd_data <= '0;
        end else begin
            if (read_fall && cart_hit) begin
                rd_oe   <= 1'b1;
                rd_data <= i_mem_rdata;
            end else if (read_rise) begin
                rd_oe <= 1'b0;
            end
        end
    end

    assign o_pi_ad     = rd_data;
    assign o_pi_ad_oe  = rd_oe;
    assign o_mem_addr  = addr.fields.offset[MEM_AW:1];
    assign o_mem_we    = write_rise & cart_hit & i_wr_en;
    assign o_mem_wdata = ad_sync;  // AD is held stable past the strobe edge.
    assign o_pi_addr   = addr;

endmodule

`default_nettype wire

//--- hdl/cart_mem.sv
`timescale 1ns/100ps
`default_nettype none

module cart_mem #(
    parameter int MEM_AW = 10
) (
    input  logic                      i_sys_clk,
    input  logic [MEM_AW-1:0]         i_a_addr,
    input  logic                      i_a_we,
    input  logic [sc64_pkg::PI_W-1:0] i_a_wdata,
    input  logic [MEM_AW-1:0]         i_b_addr,
    input  logic                      i_b_we,
    input  logic [sc64_pkg::PI_W-1:0] i_b_wdata,
    output logic [sc64_pkg::PI_W-1:0] o_a_rdata,
    output logic [sc64_pkg::PI_W-1:0] o_b_rdata
);

    localparam int DEPTH = 1 << MEM_AW;

    logic [sc64_pkg::PI_W-1:0] mem [DEPTH];
    logic [sc64_pkg::PI_W-1:0] a_rdata;
    logic [sc64_pkg::PI_W-1:0] b_rdata;

    // Port A is written last so its data stays on a collision.
    always_ff @(posedge i_sys_clk) begin
        if (i_b_we) begin
            mem[i_b_addr] <= i_b_wdata;
        end
        if (i_a_we) begin
            mem[i_a_addr] <= i_a_wdata;
        end
    end

    always_ff @(posedge i_sys_clk) begin
        a_rdata <= mem[i_a_addr];
        b_rdata <= mem[i_b_addr];
    end

    assign o_a_rdata = a_rdata;
    assign o_b_rdata = b_rdata;

endmodule

`default_nettype wire

//--- hdl/cpu_regs.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_regs #(
    parameter int MEM_AW = 10
) (
    input  logic                        i_sys_clk,
    input  logic                        i_arst_n,
    input  logic [sc64_pkg::REG_AW-1:0] i_reg_addr,
    input  logic                        i_reg_wr,
    input  logic                        i_reg_rd,
    input  logic [sc64_pkg::REG_DW-1:0] i_reg_wdata,
    input  logic [7:0]                  i_gpio_in,
    input  sc64_pkg::pi_addr_t          i_pi_addr,
    input  logic [sc64_pkg::PI_W-1:0]   i_mem_rdata,
    output logic [sc64_pkg::REG_DW-1:0] o_reg_rdata,
    output logic                        o_reg_rvalid,
    output logic [7:0]                  o_gpio_o,
    output logic [7:0]                  o_gpio_oe,
    output logic                        o_wr_en,
    output logic [MEM_AW-1:0]           o_mem_addr,
    output logic                        o_mem_we,
    output logic [sc64_pkg::PI_W-1:0]   o_mem_wdata
);

    logic [7:0]                  gpio_o;
    logic [7:0]                  gpio_oe;
    logic                        wr_en;
    logic [MEM_AW-1:0]           mem_addr;
    logic                        wr_mem;
    logic                        rd_mem;
    logic                        rd_mem_pend;
    logic [sc64_pkg::REG_DW-1:0] rd_mux;
    logic [sc64_pkg::REG_DW-1:0] rdata;
    logic                        rvalid;

    assign wr_mem = i_reg_wr && (i_reg_addr == sc64_pkg::REG_MEM_DATA);
    assign rd_mem = i_reg_rd && (i_reg_addr == sc64_pkg::REG_MEM_DATA);

    always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            gpio_o   <= 8'h00;
            gpio_oe  <= 8'h00;
            wr_en    <= 1'b0;
            mem_addr <= '0;
        end else begin
            if (i_reg_wr) begin
                case (i_reg_addr)
                    sc64_pkg::REG_GPIO: begin
                        gpio_o  <= i_reg_wdata[7:0];
                        gpio_oe <= i_reg_wdata[15:8];
                    end
                    sc64_pkg::REG_CFG: begin
                        wr_en <= i_reg_wdata[0];
                    end
                    sc64_pkg::REG_MEM_ADDR: begin
                        mem_addr <= i_reg_wdata[MEM_AW-1:0];
                    end
                    default: begin
                    end
                endcase
            end
            if (wr_mem || rd_mem) begin
                mem_addr <= mem_addr + 1'b1;  // Window steps one word per access.
            end
        end
    end

    always_comb begin
        rd_mux = '0;
        case (i_reg_addr)
            sc64_pkg::REG_GPIO: begin
                rd_mux[7:0]   = gpio_o;
                rd_mux[15:8]  = gpio_oe;
                rd_mux[23:16] = i_gpio_in;
            end
            sc64_pkg::REG_CFG: begin
                rd_mux[0] = wr_en;
            end
            sc64_pkg::REG_MEM_ADDR: begin
                rd_mux[MEM_AW-1:0] = mem_addr;
            end
            sc64_pkg::REG_PI_STATUS: begin
                rd_mux = i_pi_addr;
            end
            default: begin
                rd_mux = '0;
            end
        endcase
    end

    // Window reads wait one more cycle for the memory output.
    always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rd_mem_pend <= 1'b0;
            rvalid      <= 1'b0;
            rdata       <= '0;
        end else begin
            rd_mem_pend <= rd_mem;
            rvalid      <= 1'b0;
            if (rd_mem_pend) begin
                rdata  <= {{(sc64_pkg::REG_DW-sc64_pkg::PI_W){1'b0}}, i_mem_rdata};
                rvalid <= 1'b1;
            end else if (i_reg_rd && !rd_mem) begin
                rdata  <= rd_mux;
                rvalid <= 1'b1;
            end
        end
    end

    assign o_reg_rdata  = rdata;
    assign o_reg_rvalid = rvalid;
    assign o_gpio_o     = gpio_o;
    assign o_gpio_oe    = gpio_oe;
    assign o_wr_en      = wr_en;
    assign o_mem_addr   = mem_addr;
    assign o_mem_we     = wr_mem;
    assign o_mem_wdata  = i_reg_wdata[sc64_pkg::PI_W-1:0];

endmodule

`default_nettype wire

//--- hdl/sc64_top.sv
`timescale 1ns/100ps
`default_nettype none

module sc64_top #(
    parameter int MEM_AW = 10
) (
    input  logic                        i_sys_clk,
    input  logic                        i_arst_n,
    input  logic                        i_n64_reset,
    input  logic                        i_n64_nmi,
    input  logic                        i_pi_aleh,
    input  logic                        i_pi_alel,
    input  logic                        i_pi_read_n,
    input  logic                        i_pi_write_n,
    input  logic [15:0]                 i_pi_ad,
    input  logic [sc64_pkg::REG_AW-1:0] i_reg_addr,
    input  logic                        i_reg_wr,
    input  logic                        i_reg_rd,
    input  logic [31:0]                 i_reg_wdata,
    output logic [15:0]                 o_pi_ad,
    output logic                        o_pi_ad_oe,
    output logic [31:0]                 o_reg_rdata,
    output logic                        o_reg_rvalid,
    output logic                        o_led,
    output logic                        o_led_oe,
    output logic                        o_n64_irq,
    output logic                        o_n64_irq_oe
);

    logic [7:0]                gpio_o;
    logic [7:0]                gpio_oe;
    logic [7:0]                gpio_in;
    logic [1:0]                pin_state;
    logic                      wr_en;
    sc64_pkg::pi_addr_t        pi_addr;
    logic [MEM_AW-1:0]         a_addr;
    logic                      a_we;
    logic [sc64_pkg::PI_W-1:0] a_wdata;
    logic [sc64_pkg::PI_W-1:0] a_rdata;
    logic [MEM_AW-1:0]         b_addr;
    logic                      b_we;
    logic [sc64_pkg::PI_W-1:0] b_wdata;
    logic [sc64_pkg::PI_W-1:0] b_rdata;

    // An undriven pin reads back as 0.
    assign pin_state = {gpio_oe[1] & gpio_o[1], gpio_oe[0] & gpio_o[0]};

    n64_sync u_sync (
        .i_sys_clk   (i_sys_clk),
        .i_arst_n    (i_arst_n),
        .i_n64_reset (i_n64_reset),
        .i_n64_nmi   (i_n64_nmi),
        .i_pin_state (pin_state),
        .o_n64_reset (),
        .o_n64_nmi   (),
        .o_gpio_in   (gpio_in)
    );

    n64_pi #(.MEM_AW(MEM_AW)) u_pi (
        .i_sys_clk    (i_sys_clk),
        .i_arst_n     (i_arst_n),
        .i_pi_aleh    (i_pi_aleh),
        .i_pi_alel    (i_pi_alel),
        .i_pi_read_n  (i_pi_read_n),
        .i_pi_write_n (i_pi_write_n),
        .i_pi_ad      (i_pi_ad),
        .i_wr_en      (wr_en),
        .i_mem_rdata  (a_rdata),
        .o_pi_ad      (o_pi_ad),
        .o_pi_ad_oe   (o_pi_ad_oe),
        .o_mem_addr   (a_addr),
        .o_mem_we     (a_we),
        .o_mem_wdata  (a_wdata),
        .o_pi_addr    (pi_addr)
    );

    cart_mem #(.MEM_AW(MEM_AW)) u_mem (
        .i_sys_clk (i_sys_clk),
        .i_a_addr  (a_addr),
        .i_a_we    (a_we),
        .i_a_wdata (a_wdata),
        .i_b_addr  (b_addr),
        .i_b_we    (b_we),
        .i_b_wdata (b_wdata),
        .o_a_rdata (a_rdata),
        .o_b_rdata (b_rdata)
    );

    cpu_regs #(.MEM_AW(MEM_AW)) u_regs (
        .i_sys_clk    (i_sys_clk),
        .i_arst_n     (i_arst_n),
        .i_reg_addr   (i_reg_addr),
        .i_reg_wr     (i_reg_wr),
        .i_reg_rd     (i_reg_rd),
        .i_reg_wdata  (i_reg_wdata),
        .i_gpio_in    (gpio_in),
        .i_pi_addr    (pi_addr),
        .i_mem_rdata  (b_rdata),
        .o_reg_rdata  (o_reg_rdata),
        .o_reg_rvalid (o_reg_rvalid),
        .o_gpio_o     (gpio_o),
        .o_gpio_oe    (gpio_oe),
        .o_wr_en      (wr_en),
        .o_mem_addr   (b_addr),
        .o_mem_we     (b_we),
        .o_mem_wdata  (b_wdata)
    );

    assign o_led        = gpio_o[0];
    assign o_led_oe     = gpio_oe[0];
    assign o_n64_irq    = gpio_o[1];
    assign o_n64_irq_oe = gpio_oe[1];

endmodule

`default_nettype wire

//--- verif/tb_sc64.sv
`timescale 1ns/100ps
`default_nettype none

module tb_sc64;

    localparam int MEM_AW    = 10;
    localparam int CLK_NS    = 10;
    localparam int N_WORDS   = 64;
    localparam int BURST     = 8;
    localparam int BASE      = 'h040;  // Word address of the block loaded by the CPU.
    localparam int N_ACCESS  = 2 * N_WORDS + BURST + 60;  // Every register and PI access.
    localparam int WORST_CYC = 40;  // Upper bound on the cycles of one PI or register access.

    logic                        i_sys_clk = 1'b0;
    logic                        i_arst_n;
    logic                        i_n64_reset;
    logic                        i_n64_nmi;
    logic                        i_pi_aleh;
    logic                        i_pi_alel;
    logic                        i_pi_read_n;
    logic                        i_pi_write_n;
    logic [15:0]                 i_pi_ad;
    logic [sc64_pkg::REG_AW-1:0] i_reg_addr;
    logic                        i_reg_wr;
    logic                        i_reg_rd;
    logic [31:0]                 i_reg_wdata;
    logic [15:0]                 o_pi_ad;
    logic                        o_pi_ad_oe;
    logic [31:0]                 o_reg_rdata;
    logic                        o_reg_rvalid;
    logic                        o_led;
    logic                        o_led_oe;
    logic                        o_n64_irq;
    logic                        o_n64_irq_oe;

    logic [15:0] model [1 << MEM_AW];
    int          seed = 25402;
    int          errors = 0;
    int          checks = 0;

    sc64_top #(.MEM_AW(MEM_AW)) dut (.*);

    always #(CLK_NS / 2) i_sys_clk = ~i_sys_clk;

    initial begin
        #(CLK_NS * (N_ACCESS * WORST_CYC + 500));
        $display("Watchdog expired before the tests finished.");
        $display("ERRORS FOUND");
        $finish;
    end

    // The data driver may only turn on while the console holds read_n low.
    oe_in_read: assert property (@(posedge i_sys_clk) disable iff (!i_arst_n)
        $rose(o_pi_ad_oe) |-> !i_pi_read_n)
        else begin
            errors++;
            $display("PI output enable rose while read_n was high.");
        end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        value_ok: assert (got === exp) else begin
            errors++;
            $display("MISMATCH %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        cond_ok: assert (cond) else begin
            errors++;
            $display("Check failed: %s.", what);
        end
    endtask

    function automatic logic [31:0] pi_address(input logic [3:0] region, input int word);
        return {region, 28'(2 * word)};  // Byte offset of a 16-bit word.
    endfunction

    task automatic reg_write(input logic [2:0] addr, input logic [31:0] data);
        @(posedge i_sys_clk);
        i_reg_addr  <= addr;
        i_reg_wdata <= data;
        i_reg_wr    <= 1'b1;
        @(posedge i_sys_clk);
        i_reg_wr <= 1'b0;
    endtask

    task automatic reg_check(input logic [2:0] addr, input int lat_exp,
                             input logic [31:0] exp, input string name);
        int lat;
        lat = 0;
        @(posedge i_sys_clk);
        i_reg_addr <= addr;
        i_reg_rd   <= 1'b1;
        @(posedge i_sys_clk);
        i_reg_rd <= 1'b0;
        do begin
            @(negedge i_sys_clk);
            lat++;
        end while (!o_reg_rvalid && lat < 8);
        check_true(o_reg_rvalid, "register read timed out without rvalid");
        check_value("rvalid_delay", lat_exp, lat);
        check_value(name, exp, o_reg_rdata);
    endtask

    task automatic mem_compare(input int start, input int count);
        int k;
        reg_write(sc64_pkg::REG_MEM_ADDR, start);
        for (k = 0; k < count; k++) begin
            reg_check(sc64_pkg::REG_MEM_DATA, 2, model[start + k], "mem_data");
        end
    endtask

    task automatic pi_latch(input logic [31:0] addr);
        @(posedge i_sys_clk);
        i_pi_ad   <= addr[31:16];
        i_pi_aleh <= 1'b1;
        i_pi_alel <= 1'b1;
        repeat (4) @(posedge i_sys_clk);
        i_pi_aleh <= 1'b0;
        repeat (4) @(posedge i_sys_clk);
        i_pi_ad <= addr[15:0];
        repeat (4) @(posedge i_sys_clk);
        i_pi_alel <= 1'b0;
        repeat (4) @(posedge i_sys_clk);
    endtask

    task automatic pi_read(input logic hit, input logic [15:0] exp);
        int n;
        n = 0;
        @(posedge i_sys_clk);
        i_pi_read_n <= 1'b0;
        do begin
            @(negedge i_sys_clk);
            n++;
        end while (!o_pi_ad_oe && n < 8);
        if (hit) begin
            check_true(o_pi_ad_oe && n <= 4, "PI read data missing 4 cycles after read_n fell");
            check_value("o_pi_ad", exp, o_pi_ad);
        end else begin
            check_true(!o_pi_ad_oe, "PI output enable rose outside the cart region");
        end
        @(posedge i_sys_clk);
        i_pi_read_n <= 1'b1;
        repeat (6) @(negedge i_sys_clk);
        check_true(!o_pi_ad_oe, "PI output enable stayed high after read_n rose");
    endtask

    task automatic pi_write(input logic [15:0] data);
        @(posedge i_sys_clk);
        i_pi_ad <= data;
        repeat (4) @(posedge i_sys_clk);
        i_pi_write_n <= 1'b0;
        repeat (4) @(posedge i_sys_clk);
        i_pi_write_n <= 1'b1;  // Data is taken on this edge.
        repeat (5) @(posedge i_sys_clk);
    endtask

    task automatic gpio_case(input logic [7:0] gpo, input logic [7:0] gpoe,
                             input logic nmi, input logic rst);
        logic [7:0] pins;
        pins = {4'b0000, nmi, rst, gpo[1] & gpoe[1], gpo[0] & gpoe[0]};
        reg_write(sc64_pkg::REG_GPIO, {16'h0000, gpoe, gpo});
        @(posedge i_sys_clk);
        i_n64_nmi   <= nmi;
        i_n64_reset <= rst;
        @(negedge i_sys_clk);
        check_value("o_led", gpo[0], o_led);
        check_value("o_led_oe", gpoe[0], o_led_oe);
        check_value("o_n64_irq", gpo[1], o_n64_irq);
        check_value("o_n64_irq_oe", gpoe[1], o_n64_irq_oe);
        repeat (3) @(posedge i_sys_clk);  // Two sync stages and the gpio_in register.
        reg_check(sc64_pkg::REG_GPIO, 1, {8'h00, pins, gpoe, gpo}, "gpio_rdata");
    endtask

    initial begin
        int          i;
        logic [31:0] w;
        i_arst_n     = 1'b1;
        i_n64_reset  = 1'b0;
        i_n64_nmi    = 1'b0;
        i_pi_aleh    = 1'b0;
        i_pi_alel    = 1'b0;
        i_pi_read_n  = 1'b1;
        i_pi_write_n = 1'b1;
        i_pi_ad      = 16'h0000;
        i_reg_addr   = '0;
        i_reg_wr     = 1'b0;
        i_reg_rd     = 1'b0;
        i_reg_wdata  = 32'h0;

        @(posedge i_sys_clk);
        i_arst_n <= 1'b0;
        repeat (16) begin
            @(negedge i_sys_clk);
            check_true(!(o_pi_ad_oe | o_led_oe | o_n64_irq_oe | o_reg_rvalid),
                       "an enable or rvalid was high during reset");
        end
        @(posedge i_sys_clk);
        i_arst_n <= 1'b1;
        @(negedge i_sys_clk);
        check_true(!(o_pi_ad_oe | o_led_oe | o_n64_irq_oe | o_reg_rvalid),
                   "an enable or rvalid was high after reset");
        for (i = 0; i < 8; i++) begin
            if (i != sc64_pkg::REG_MEM_DATA) begin
                reg_check(i[2:0], 1, 32'h0, "reset_rdata");
            end
        end

        reg_write(sc64_pkg::REG_MEM_ADDR, BASE);
        for (i = 0; i < N_WORDS; i++) begin
            w = $random(seed);
            model[BASE + i] = w[15:0];
            reg_write(sc64_pkg::REG_MEM_DATA, w);
        end
        reg_check(sc64_pkg::REG_MEM_ADDR, 1, BASE + N_WORDS, "mem_addr");
        mem_compare(BASE, N_WORDS);

        pi_latch(pi_address(sc64_pkg::CART_REGION, BASE));
        for (i = 0; i < BURST; i++) begin
            pi_read(1'b1, model[BASE + i]);
        end
        reg_check(sc64_pkg::REG_PI_STATUS, 1, pi_address(sc64_pkg::CART_REGION, BASE + BURST),
                  "pi_status");

        reg_write(sc64_pkg::REG_CFG, 32'h0);
        pi_latch(pi_address(sc64_pkg::CART_REGION, BASE + 16));
        pi_write(~model[BASE + 16]);
        pi_write(~model[BASE + 17]);
        mem_compare(BASE + 16, 2);
        reg_write(sc64_pkg::REG_CFG, 32'h1);
        reg_check(sc64_pkg::REG_CFG, 1, 32'h1, "cfg");
        pi_latch(pi_address(sc64_pkg::CART_REGION, BASE + 16));
        for (i = 0; i < 2; i++) begin
            w = $random(seed);
            model[BASE + 16 + i] = w[15:0];
            pi_write(w[15:0]);
        end
        pi_latch(pi_address(4'd2, BASE + 16));  // Same offset, other region.
        pi_write(~model[BASE + 16]);
        pi_read(1'b0, 16'h0000);
        mem_compare(BASE + 16, 4);
        reg_check(sc64_pkg::REG_PI_STATUS, 1, pi_address(4'd2, BASE + 18), "pi_status");

        gpio_case(8'h01, 8'h03, 1'b1, 1'b0);
        gpio_case(8'h03, 8'h01, 1'b0, 1'b1);
        gpio_case(8'h03, 8'h02, 1'b1, 1'b1);

        repeat (4) @(posedge i_sys_clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
hdl/sc64_pkg.sv
hdl/n64_sync.sv
hdl/n64_pi.sv
hdl/cart_mem.sv
hdl/cpu_regs.sv
hdl/sc64_top.sv
verif/tb_sc64.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --assert -Wno-fatal --top-module tb_sc64 -f all.f -o tb_sc64_sim &&
./obj_dir/tb_sc64_sim 2>&1 | tee sim.log &&
grep -qx "NO ERRORS" sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
